//--- common/be_mem_params.svh
// Widths and data memory geometry for the memory subsystem
// Shared by the package and the RTL modules

`ifndef BE_MEM_PARAMS_SVH
`define BE_MEM_PARAMS_SVH

// Virtual address width
`define BE_VADDR_W 39

// Integer register width
`define BE_DATA_W 64

// Data memory depth in doublewords
`define BE_DMEM_WORDS 32

// Configuration data bus, wide enough for a window address
`define BE_CFG_W 39

`endif

//--- common/be_mem_pkg.sv
// Types for the memory subsystem
// Op and config select enums, decode, command, response and window structs

`include "be_mem_params.svh"

package be_mem_pkg;

   // Integer load and store operations
   typedef enum logic [3:0] {
      op_lb  = 4'd0,
      op_lh  = 4'd1,
      op_lw  = 4'd2,
      op_ld  = 4'd3,
      op_lbu = 4'd4,
      op_lhu = 4'd5,
      op_lwu = 4'd6,
      op_sb  = 4'd7,
      op_sh  = 4'd8,
      op_sw  = 4'd9,
      op_sd  = 4'd10
   } be_mem_op_e;

   // Configuration register select
   typedef enum logic {
      sel_base  = 1'b0,
      sel_limit = 1'b1
   } be_cfg_sel_e;

   typedef struct packed {
      logic       dcache_r_v;
      logic       dcache_w_v;
      logic       offset_sel;
      be_mem_op_e fu_op;
   } be_decode_s;

   typedef struct packed {
      be_mem_op_e              mem_op;
      logic [`BE_VADDR_W-1:0] vaddr;
      logic [`BE_DATA_W-1:0]  data;
   } be_mem_cmd_s;

   typedef struct packed {
      logic [`BE_VADDR_W-1:0] vaddr;
      logic [`BE_DATA_W-1:0]  data;
      logic                    cache_miss_v;
   } be_mem_resp_s;

   // Half-open window, base up to but not including limit
   typedef struct packed {
      logic [`BE_VADDR_W-1:0] base;
      logic [`BE_VADDR_W-1:0] limit;
   } be_dmem_win_s;

endpackage

//--- source/be_pipe_mem.sv
// Memory pipe for integer loads and stores
// Address generation, alignment check, command issue and result reporting

`timescale 1ns/100ps

`include "be_mem_params.svh"

module be_pipe_mem
  (input  logic                      clk_i
   , input  logic                    rst_n_i
   , input  logic                    kill_ex1_i
   , input  be_mem_pkg::be_decode_s  decode_i
   , input  logic [`BE_DATA_W-1:0]   rs1_i
   , input  logic [`BE_DATA_W-1:0]   rs2_i
   , input  logic [`BE_DATA_W-1:0]   imm_i
   , output be_mem_pkg::be_mem_cmd_s mem_cmd_o
   , output logic                    mem_cmd_v_o
   , input  be_mem_pkg::be_mem_resp_s mem_resp_i
   , input  logic                    mem_resp_v_i
   , output logic                    exc_v_o
   , output logic                    miss_v_o
   , output logic [`BE_VADDR_W-1:0]  vaddr_o
   , output logic [`BE_DATA_W-1:0]   data_o
   );

   import be_mem_pkg::*;

   logic [`BE_VADDR_W-1:0] offset;
   logic [`BE_VADDR_W-1:0] vaddr;
   logic                   is_mem;
   logic                   misaligned;
   logic [1:0]             st_pend;

   // Zero offset selected by decode, e.g. for atomics style addressing
   assign offset = decode_i.offset_sel ? '0 : imm_i[`BE_VADDR_W-1:0];
   assign vaddr  = rs1_i[`BE_VADDR_W-1:0] + offset;

   // Address must be a multiple of the access size
   always_comb
   begin
      case (decode_i.fu_op)
         op_lh, op_lhu, op_sh: misaligned = vaddr[0];
         op_lw, op_lwu, op_sw: misaligned = |vaddr[1:0];
         op_ld, op_sd:         misaligned = |vaddr[2:0];
         default:              misaligned = 1'b0;
      endcase
   end

   assign is_mem = (decode_i.dcache_r_v | decode_i.dcache_w_v) & ~kill_ex1_i;

   assign mem_cmd_o.mem_op = decode_i.fu_op;
   assign mem_cmd_o.vaddr  = vaddr;
   assign mem_cmd_o.data   = rs2_i;
   assign mem_cmd_v_o      = is_mem & ~misaligned;
   assign exc_v_o          = is_mem & misaligned;

   // Track stores in flight so their responses carry no data
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         st_pend <= '0;
      else
         st_pend <= {st_pend[0], mem_cmd_v_o & decode_i.dcache_w_v};
   end

   assign miss_v_o = mem_resp_v_i & mem_resp_i.cache_miss_v;
   assign vaddr_o  = mem_resp_i.vaddr;
   assign data_o   = st_pend[1] ? '0 : mem_resp_i.data;

endmodule

//--- dmem/be_dmem.sv
// Two-cycle data memory
// Window check, byte-lane store merge and load extension

`timescale 1ns/100ps

`include "be_mem_params.svh"

module be_dmem
  (input  logic                      clk_i
   , input  logic                    rst_n_i
   , input  be_mem_pkg::be_mem_cmd_s mem_cmd_i
   , input  logic                    mem_cmd_v_i
   , input  be_mem_pkg::be_dmem_win_s win_i
   , output be_mem_pkg::be_mem_resp_s mem_resp_o
   , output logic                    mem_resp_v_o
   );

   import be_mem_pkg::*;

   localparam int IDX_W = $clog2(`BE_DMEM_WORDS);

   logic [`BE_DATA_W-1:0] mem [`BE_DMEM_WORDS];

   be_mem_cmd_s           s1_cmd;
   logic                  s1_v;
   logic                  s1_hit;
   logic                  hit;
   logic [IDX_W-1:0]      s1_idx;
   logic [2:0]            s1_off;
   logic [`BE_DATA_W-1:0] rd_word;
   logic [`BE_DATA_W-1:0] rd_shift;
   logic [`BE_DATA_W-1:0] ld_data;
   logic [`BE_DATA_W-1:0] wr_data;
   logic [7:0]            size_mask;
   logic [7:0]            wr_mask;

   // Half-open window test on the issued address
   assign hit = (mem_cmd_i.vaddr >= win_i.base) && (mem_cmd_i.vaddr < win_i.limit);

   // Stage 1
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         s1_v <= 1'b0;
      else
         s1_v <= mem_cmd_v_i;
   end

   always_ff @(posedge clk_i)
   begin
      s1_cmd <= mem_cmd_i;
      s1_hit <= hit;
   end

   assign s1_idx   = s1_cmd.vaddr[3 +: IDX_W];
   assign s1_off   = s1_cmd.vaddr[2:0];
   assign rd_word  = mem[s1_idx];
   assign rd_shift = rd_word >> {s1_off, 3'b000};

   // Store lanes, loads write nothing
   always_comb
   begin
      case (s1_cmd.mem_op)
         op_sb:   size_mask = 8'h01;
         op_sh:   size_mask = 8'h03;
         op_sw:   size_mask = 8'h0f;
         op_sd:   size_mask = 8'hff;
         default: size_mask = 8'h00;
      endcase
   end

   assign wr_mask = size_mask << s1_off;
   assign wr_data = s1_cmd.data << {s1_off, 3'b000};

   // Extend by op; doubleword and store ops return the whole word
   always_comb
   begin
      case (s1_cmd.mem_op)
         op_lb:   ld_data = {{56{rd_shift[7]}}, rd_shift[7:0]};
         op_lh:   ld_data = {{48{rd_shift[15]}}, rd_shift[15:0]};
         op_lw:   ld_data = {{32{rd_shift[31]}}, rd_shift[31:0]};
         op_lbu:  ld_data = {56'd0, rd_shift[7:0]};
         op_lhu:  ld_data = {48'd0, rd_shift[15:0]};
         op_lwu:  ld_data = {32'd0, rd_shift[31:0]};
         default: ld_data = rd_word;
      endcase
   end

   // Stage 2 write, same edge as the response
   always_ff @(posedge clk_i)
   begin
      if (s1_v && s1_hit)
      begin
         for (int i = 0; i < 8; i++)
         begin
            if (wr_mask[i])
               mem[s1_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         mem_resp_v_o <= 1'b0;
      else
         mem_resp_v_o <= s1_v;
   end

   // Miss returns zero data
   always_ff @(posedge clk_i)
   begin
      mem_resp_o.vaddr        <= s1_cmd.vaddr;
      mem_resp_o.data         <= s1_hit ? ld_data : '0;
      mem_resp_o.cache_miss_v <= ~s1_hit;
   end

endmodule

//--- dmem/be_dmem_cfg.sv
// Configuration registers for the data memory window
// Base and limit, loaded one at a time by select

`timescale 1ns/100ps

`include "be_mem_params.svh"

module be_dmem_cfg
  (input  logic                       clk_i
   , input  logic                     rst_n_i
   , input  logic                     cfg_we_i
   , input  be_mem_pkg::be_cfg_sel_e  cfg_sel_i
   , input  logic [`BE_CFG_W-1:0]     cfg_data_i
   , output be_mem_pkg::be_dmem_win_s win_o
   );

   import be_mem_pkg::*;

   // Full memory in bytes
   localparam logic [`BE_VADDR_W-1:0] MEM_BYTES = `BE_VADDR_W'(`BE_DMEM_WORDS * 8);

   be_dmem_win_s win_r;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         win_r.base  <= '0;
         win_r.limit <= MEM_BYTES;
      end
      else if (cfg_we_i)
      begin
         case (cfg_sel_i)
            sel_base:  win_r.base  <= cfg_data_i;
            sel_limit: win_r.limit <= cfg_data_i;
            default:   win_r       <= win_r;
         endcase
      end
   end

   // Level output, new value seen from the cycle after the write
   assign win_o = win_r;

endmodule

//--- source/be_mem_top.sv
// Memory subsystem top level
// Memory pipe, data memory and window configuration block

`timescale 1ns/100ps

`include "be_mem_params.svh"

module be_mem_top
  (input  logic                      clk_i
   , input  logic                    rst_n_i
   , input  logic                    kill_ex1_i
   , input  be_mem_pkg::be_decode_s  decode_i
   , input  logic [`BE_DATA_W-1:0]   rs1_i
   , input  logic [`BE_DATA_W-1:0]   rs2_i
   , input  logic [`BE_DATA_W-1:0]   imm_i
   , output logic                    exc_v_o
   , output logic                    miss_v_o
   , output logic [`BE_VADDR_W-1:0]  vaddr_o
   , output logic [`BE_DATA_W-1:0]   data_o
   , input  logic                    cfg_we_i
   , input  be_mem_pkg::be_cfg_sel_e cfg_sel_i
   , input  logic [`BE_CFG_W-1:0]    cfg_data_i
   );

   import be_mem_pkg::*;

   be_mem_cmd_s  mem_cmd;
   logic         mem_cmd_v;
   be_mem_resp_s mem_resp;
   logic         mem_resp_v;
   be_dmem_win_s win;

   be_pipe_mem u_pipe_mem
     (.clk_i        (clk_i)
      , .rst_n_i      (rst_n_i)
      , .kill_ex1_i   (kill_ex1_i)
      , .decode_i     (decode_i)
      , .rs1_i        (rs1_i)
      , .rs2_i        (rs2_i)
      , .imm_i        (imm_i)
      , .mem_cmd_o    (mem_cmd)
      , .mem_cmd_v_o  (mem_cmd_v)
      , .mem_resp_i   (mem_resp)
      , .mem_resp_v_i (mem_resp_v)
      , .exc_v_o      (exc_v_o)
      , .miss_v_o     (miss_v_o)
      , .vaddr_o      (vaddr_o)
      , .data_o       (data_o)
      );

   be_dmem u_dmem
     (.clk_i          (clk_i)
      , .rst_n_i      (rst_n_i)
      , .mem_cmd_i    (mem_cmd)
      , .mem_cmd_v_i  (mem_cmd_v)
      , .win_i        (win)
      , .mem_resp_o   (mem_resp)
      , .mem_resp_v_o (mem_resp_v)
      );

   be_dmem_cfg u_dmem_cfg
     (.clk_i        (clk_i)
      , .rst_n_i    (rst_n_i)
      , .cfg_we_i   (cfg_we_i)
      , .cfg_sel_i  (cfg_sel_i)
      , .cfg_data_i (cfg_data_i)
      , .win_o      (win)
      );

endmodule

//--- test/be_mem_checker.sv
// Bound assertions on the memory subsystem
// Command to response latency, exception exclusivity, reset behavior

`timescale 1ns/100ps

module be_mem_checker
  (input  logic   clk_i
   , input  logic rst_n_i
   , input  logic cmd_v_i
   , input  logic resp_v_i
   , input  logic exc_v_i
   );

   int fail_cnt = 0;

   // Response strobe exactly two edges after its command
   resp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_v_i == $past(cmd_v_i, 2))
   else
   begin
      fail_cnt++;
      $error("Response strobe does not follow the command by two cycles");
   end

   // A misaligned access never issues
   exc_cmd_excl: assert property (@(posedge clk_i) !(exc_v_i && cmd_v_i))
   else
   begin
      fail_cnt++;
      $error("Exception and command strobe high together");
   end

   // Synchronous reset clears the response strobe
   resp_in_reset: assert property (@(posedge clk_i) $past(!rst_n_i) |-> !resp_v_i)
   else
   begin
      fail_cnt++;
      $error("Response strobe high during reset");
   end

endmodule

bind be_mem_top be_mem_checker u_mem_checker
  (.clk_i      (clk_i)
   , .rst_n_i  (rst_n_i)
   , .cmd_v_i  (mem_cmd_v)
   , .resp_v_i (mem_resp_v)
   , .exc_v_i  (exc_v_o)
   );

//--- test/be_mem_monitor.sv
// Monitor for the memory subsystem
// Per-cycle exception and issue checks, in-order response checks, error counts

`timescale 1ns/100ps

`include "be_mem_params.svh"

module be_mem_monitor
  (input  logic                   clk_i
   , input  logic                 rst_n_i
   , input  logic                 cmd_v_i
   , input  logic                 resp_v_i
   , input  logic                 exc_v_i
   , input  logic                 miss_v_i
   , input  logic [`BE_VADDR_W-1:0] vaddr_i
   , input  logic [`BE_DATA_W-1:0]  data_i
   );

   typedef struct packed {
      logic [`BE_VADDR_W-1:0] vaddr;
      logic                   miss;
      logic [`BE_DATA_W-1:0]  data;
   } resp_exp_s;

   resp_exp_s resp_q[$];
   resp_exp_s head;
   logic      exp_exc = 1'b0;
   logic      exp_cmd = 1'b0;
   int        err_cnt = 0;
   int        chk_cnt = 0;

   // Expectation for the cycle just driven, idle otherwise
   task automatic expect_cycle(input logic exc, input logic cmd);
      exp_exc = exc;
      exp_cmd = cmd;
   endtask

   task automatic push_resp(input logic [`BE_VADDR_W-1:0] vaddr, input logic miss,
                            input logic [`BE_DATA_W-1:0] data);
      resp_q.push_back({vaddr, miss, data});
   endtask

   function automatic int pending();
      return resp_q.size();
   endfunction

   task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Mid-cycle sampling, inputs and registered outputs are settled
   always @(negedge clk_i)
   begin
      if (rst_n_i)
      begin
         compare("exc_v_o", 64'(exc_v_i), 64'(exp_exc));
         compare("command strobe", 64'(cmd_v_i), 64'(exp_cmd));
         exp_exc = 1'b0;
         exp_cmd = 1'b0;
         if (!resp_v_i)
            compare("miss_v_o without response", 64'(miss_v_i), 64'd0);
         else if (resp_q.size() == 0)
         begin
            err_cnt++;
            $display("Response at %0t ns with no command waiting for it", $time);
         end
         else
         begin
            head = resp_q.pop_front();
            compare("vaddr_o", 64'(vaddr_i), 64'(head.vaddr));
            compare("miss_v_o", 64'(miss_v_i), 64'(head.miss));
            compare("data_o", data_i, head.data);
         end
      end
   end

endmodule

//--- test/be_mem_tb.sv
// Testbench for the memory subsystem
// Clock, reset, window configuration, stimulus table and its reference model

`timescale 1ns/100ps

`include "be_mem_params.svh"

module be_mem_tb;

   import be_mem_pkg::*;

   typedef struct packed {
      be_mem_op_e             op;
      logic [63:0]            rs1;
      logic [63:0]            imm;
      logic                   osel;
      logic [63:0]            rs2;
      logic                   kill;
      logic [`BE_VADDR_W-1:0] exp_vaddr;
      logic                   exp_exc;
      logic                   exp_miss;
      logic [63:0]            exp_data;
   } entry_s;

   logic                   clk;
   logic                   rst_n;
   logic                   kill_ex1;
   be_decode_s             decode;
   logic [`BE_DATA_W-1:0]  rs1;
   logic [`BE_DATA_W-1:0]  rs2;
   logic [`BE_DATA_W-1:0]  imm;
   logic                   exc_v;
   logic                   miss_v;
   logic [`BE_VADDR_W-1:0] vaddr;
   logic [`BE_DATA_W-1:0]  data;
   logic                   cfg_we;
   be_cfg_sel_e            cfg_sel;
   logic [`BE_CFG_W-1:0]   cfg_data;

   entry_s                 table_q[$];
   logic [7:0]             shadow [256];
   logic [`BE_VADDR_W-1:0] win_base;
   logic [`BE_VADDR_W-1:0] win_limit;
   logic [63:0]            rnd;
   int                     cycles;
   int                     timeouts;
   int                     total_err;

   be_mem_top dut
     (.clk_i        (clk)
      , .rst_n_i    (rst_n)
      , .kill_ex1_i (kill_ex1)
      , .decode_i   (decode)
      , .rs1_i      (rs1)
      , .rs2_i      (rs2)
      , .imm_i      (imm)
      , .exc_v_o    (exc_v)
      , .miss_v_o   (miss_v)
      , .vaddr_o    (vaddr)
      , .data_o     (data)
      , .cfg_we_i   (cfg_we)
      , .cfg_sel_i  (cfg_sel)
      , .cfg_data_i (cfg_data)
      );

   be_mem_monitor mon
     (.clk_i      (clk)
      , .rst_n_i  (rst_n)
      , .cmd_v_i  (dut.mem_cmd_v)
      , .resp_v_i (dut.mem_resp_v)
      , .exc_v_i  (exc_v)
      , .miss_v_i (miss_v)
      , .vaddr_i  (vaddr)
      , .data_i   (data)
      );

   always #5 clk = ~clk;

   initial
   begin
      rst_n = 1'b0;
      for (int i = 0; i < 3; i++)
         @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

   function automatic int access_size(input be_mem_op_e op);
      case (op)
         op_lb, op_lbu, op_sb: return 1;
         op_lh, op_lhu, op_sh: return 2;
         op_lw, op_lwu, op_sw: return 4;
         default:              return 8;
      endcase
   endfunction

   function automatic logic is_store_op(input be_mem_op_e op);
      return op inside {op_sb, op_sh, op_sw, op_sd};
   endfunction

   // Little-endian bytes from the shadow memory, extended by the op
   function automatic logic [63:0] load_value(input be_mem_op_e op, input logic [7:0] a);
      logic [63:0] raw;
      raw = '0;
      for (int i = 0; i < access_size(op); i++)
         raw[i*8 +: 8] = shadow[a + 8'(i)];
      case (op)
         op_lb:   return {{56{raw[7]}}, raw[7:0]};
         op_lh:   return {{48{raw[15]}}, raw[15:0]};
         op_lw:   return {{32{raw[31]}}, raw[31:0]};
         default: return raw;
      endcase
   endfunction

   // Builds one entry and its expected outcome against the current window
   task automatic add_entry(input be_mem_op_e op, input logic [63:0] r1, input logic [63:0] im,
                            input logic osel, input logic [63:0] r2, input logic kill);
      entry_s                 e;
      logic [`BE_VADDR_W-1:0] addr;
      logic                   hit;
      int                     size;
      addr = osel ? r1[`BE_VADDR_W-1:0] : r1[`BE_VADDR_W-1:0] + im[`BE_VADDR_W-1:0];
      size = access_size(op);
      hit = (addr >= win_base) && (addr < win_limit);
      e.op = op;
      e.rs1 = r1;
      e.imm = im;
      e.osel = osel;
      e.rs2 = r2;
      e.kill = kill;
      e.exp_vaddr = addr;
      e.exp_exc = !kill && ((addr & `BE_VADDR_W'(size - 1)) != '0);
      e.exp_miss = !kill && !e.exp_exc && !hit;
      e.exp_data = '0;
      if (!kill && !e.exp_exc && hit)
      begin
         if (is_store_op(op))
         begin
            for (int i = 0; i < size; i++)
               shadow[addr[7:0] + 8'(i)] = r2[i*8 +: 8];
         end
         else
            e.exp_data = load_value(op, addr[7:0]);
      end
      table_q.push_back(e);
   endtask

   task automatic drive_idle();
      kill_ex1 = 1'b0;
      decode = '0;
      rs1 = '0;
      rs2 = '0;
      imm = '0;
   endtask

   // One entry per cycle with expectations handed to the monitor
   task automatic run_table();
      entry_s e;
      logic   issue;
      for (int n = 0; n < table_q.size(); n++)
      begin
         e = table_q[n];
         @(posedge clk);
         #1;
         kill_ex1 = e.kill;
         decode.dcache_r_v = !is_store_op(e.op);
         decode.dcache_w_v = is_store_op(e.op);
         decode.offset_sel = e.osel;
         decode.fu_op = e.op;
         rs1 = e.rs1;
         rs2 = e.rs2;
         imm = e.imm;
         issue = !e.kill && !e.exp_exc;
         mon.expect_cycle(e.exp_exc, issue);
         if (issue)
            mon.push_resp(e.exp_vaddr, e.exp_miss, e.exp_data);
      end
      table_q.delete();
      @(posedge clk);
      #1;
      drive_idle();
   endtask

   task automatic wait_drain();
      cycles = 0;
      while (mon.pending() != 0 && cycles < 10)
      begin
         @(posedge clk);
         cycles++;
      end
      if (mon.pending() != 0)
      begin
         $display("Timeout: %0d responses never arrived", mon.pending());
         timeouts++;
      end
   endtask

   task automatic write_cfg(input be_cfg_sel_e sel, input logic [`BE_CFG_W-1:0] value);
      @(posedge clk);
      #1;
      cfg_we = 1'b1;
      cfg_sel = sel;
      cfg_data = value;
      @(posedge clk);
      #1;
      cfg_we = 1'b0;
      if (sel == sel_base)
         win_base = value;
      else
         win_limit = value;
   endtask

   initial
   begin
      clk = 1'b0;
      drive_idle();
      cfg_we = 1'b0;
      cfg_sel = sel_base;
      cfg_data = '0;
      win_base = '0;
      win_limit = `BE_VADDR_W'(256);
      timeouts = 0;
      void'($urandom(32'h8977));

      cycles = 0;
      while (!rst_n && cycles < 20)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!rst_n)
      begin
         $display("Timeout: reset was never released");
         timeouts++;
      end

      // Fill all sizes with sign bits forced so both extensions show
      rnd = {$urandom, $urandom};
      add_entry(op_sd, 64'h00, 64'h0, 1'b0, rnd, 1'b0);
      rnd = {$urandom, $urandom} | 64'h8000_0000;
      add_entry(op_sw, 64'h10, 64'h0, 1'b0, rnd, 1'b0);
      rnd = {$urandom, $urandom} | 64'h8000;
      add_entry(op_sh, 64'h18, 64'h2, 1'b0, rnd, 1'b0);
      rnd = {$urandom, $urandom} | 64'h80;
      add_entry(op_sb, 64'h20, 64'h7, 1'b0, rnd, 1'b0);
      rnd = {$urandom, $urandom};
      add_entry(op_sd, 64'h30, 64'h0, 1'b0, rnd, 1'b0);
      // Load right behind the store to the same doubleword
      add_entry(op_ld, 64'h30, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_ld, 64'h00, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lw, 64'h10, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lwu, 64'h10, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lh, 64'h1a, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lhu, 64'h1a, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lb, 64'h27, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lbu, 64'h27, 64'h0, 1'b0, 64'h0, 1'b0);
      // Immediate ignored when offset select is set
      add_entry(op_ld, 64'h30, 64'h48, 1'b1, 64'h0, 1'b0);
      add_entry(op_lw, 64'h08, 64'h08, 1'b0, 64'h0, 1'b0);
      add_entry(op_ld, 64'h40, -64'sd16, 1'b0, 64'h0, 1'b0);
      // Misaligned word accesses leave the memory unchanged
      add_entry(op_sw, 64'h12, 64'h0, 1'b0, 64'h1111_2222_3333_4444, 1'b0);
      add_entry(op_lw, 64'h12, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lw, 64'h10, 64'h0, 1'b0, 64'h0, 1'b0);
      // Killed store and load
      add_entry(op_sd, 64'h00, 64'h0, 1'b0, 64'h5555_aaaa_5555_aaaa, 1'b1);
      add_entry(op_ld, 64'h00, 64'h0, 1'b0, 64'h0, 1'b1);
      add_entry(op_ld, 64'h00, 64'h0, 1'b0, 64'h0, 1'b0);
      run_table();
      wait_drain();

      // Narrow window 64 up to 128
      write_cfg(sel_base, `BE_CFG_W'(64));
      write_cfg(sel_limit, `BE_CFG_W'(128));
      add_entry(op_sd, 64'h40, 64'h0, 1'b0, 64'h0123_4567_89ab_cdef, 1'b0);
      add_entry(op_sd, 64'h78, 64'h0, 1'b0, 64'hfedc_ba98_7654_3210, 1'b0);
      add_entry(op_ld, 64'h40, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_ld, 64'h78, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_ld, 64'h80, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_ld, 64'h38, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_sd, 64'h00, 64'h0, 1'b0, 64'h0f0f_0f0f_0f0f_0f0f, 1'b0);
      add_entry(op_ld, 64'h00, 64'h0, 1'b0, 64'h0, 1'b0);
      run_table();
      wait_drain();

      // Old data still in place under the full window
      write_cfg(sel_base, `BE_CFG_W'(0));
      write_cfg(sel_limit, `BE_CFG_W'(256));
      add_entry(op_ld, 64'h00, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_ld, 64'h40, 64'h0, 1'b0, 64'h0, 1'b0);
      add_entry(op_lbu, 64'h27, 64'h0, 1'b0, 64'h0, 1'b0);
      run_table();
      wait_drain();
      for (int i = 0; i < 3; i++)
         @(posedge clk);

      total_err = mon.err_cnt + dut.u_mem_checker.fail_cnt + timeouts;
      $display("Checks: %0d, monitor errors: %0d, assertion failures: %0d, timeouts: %0d",
               mon.chk_cnt, mon.err_cnt, dut.u_mem_checker.fail_cnt, timeouts);
      if (total_err == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- be_mem.f
+incdir+common
common/be_mem_pkg.sv
source/be_pipe_mem.sv
dmem/be_dmem.sv
dmem/be_dmem_cfg.sv
source/be_mem_top.sv
test/be_mem_checker.sv
test/be_mem_monitor.sv
test/be_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module be_mem_tb -f be_mem.f -Mdir obj_dir

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/Vbe_mem_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log
then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
